/* verilog.f */
rtl/loader_pkg.sv
rtl/ioctl_if.sv
rtl/rom_wr_if.sv
rtl/cart_loader.sv
rtl/rom_signature_check.sv
rtl/cheat_code_assembler.sv
rtl/cd_sector_unpacker.sv
rtl/tgfx_loader_top.sv
tests/loader_checker.sv
tests/loader_tb.sv

/* tests/loader_tb.sv */
// Directed tests of the download front end; ROM model acks after 0 to 7 cycles, stops at first error
`timescale 1ns/1ps

module loader_tb;

	localparam int CART_WORDS = 64;
	// 'h2140 byte image
	localparam int SIG_WORDS = 'h10A0;
	localparam int TOTAL_WORDS = 2 * CART_WORDS + SIG_WORDS + 8 + 4;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 1000;

	logic                      clk_sys;
	logic                      reset;
	logic                      ioctl_download;
	loader_pkg::ioctl_index_t  ioctl_index;
	logic                      ioctl_wr;
	loader_pkg::ioctl_addr_t   ioctl_addr;
	loader_pkg::word_t         ioctl_dout;
	logic                      ioctl_wait;
	logic                      swap_bytes;
	loader_pkg::rom_addr_t     rom_wr_addr;
	loader_pkg::word_t         rom_wr_data;
	logic                      rom_wr_req;
	logic                      rom_wr_ack;
	loader_pkg::bank_flags_t   populous;
	logic                      sgx;
	loader_pkg::cheat_code_t   cheat_code;
	logic                      cheat_valid;
	loader_pkg::byte_t         cd_data;
	logic                      cd_wr;
	logic                      cd_mode;

	logic [15:0]        stim_lfsr = 16'd10;
	logic [15:0]        rom_lfsr = 16'd10;
	loader_pkg::word_t  rom_mem [loader_pkg::rom_addr_t];
	loader_pkg::byte_t  cd_bytes [$];
	int                 valid_count = 0;

	tgfx_loader_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [15:0] galois_step(input logic [15:0] state);
		galois_step = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic draw_word(output loader_pkg::word_t value);
		value = '0;
		for (int b = 0; b < 16; b++) begin
			stim_lfsr = galois_step(stim_lfsr);
			value = {value[14:0], stim_lfsr[0]};
		end
	endtask

	function automatic loader_pkg::byte_t mirror_byte(input loader_pkg::byte_t b);
		for (int i = 0; i < 8; i++) begin
			mirror_byte[i] = b[7 - i];
		end
	endfunction

	// String literals put the second character in the low byte
	function automatic loader_pkg::word_t image_word(input loader_pkg::rom_addr_t a);
		case (a)
			24'h1F26, 24'h2126: image_word = "OP";
			24'h1F28, 24'h2128: image_word = "UP";
			24'h1F2A, 24'h212A: image_word = "OL";
			24'h1F2C: image_word = "SU";
			24'h212C: image_word = "ZZ";
			default: image_word = a[15:0] ^ {a[7:0], a[23:16]} ^ 16'hC35A;
		endcase
	endfunction

	task automatic stop_with_failure();
		$display("Regression failed");
		$fatal(1, "Stopping after the first error");
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_word(input string name, input loader_pkg::word_t actual,
		input loader_pkg::word_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string name, input loader_pkg::rom_addr_t actual,
		input loader_pkg::rom_addr_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_flags(input string name, input loader_pkg::bank_flags_t actual,
		input loader_pkg::bank_flags_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_code(input string name, input loader_pkg::cheat_code_t actual,
		input loader_pkg::cheat_code_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_byte(input string name, input loader_pkg::byte_t actual,
		input loader_pkg::byte_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	//////////////////////////////////////////////////
	// Host bus driving
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic start_download(input loader_pkg::ioctl_index_t index);
		ioctl_index = index;
		ioctl_download = 1'b1;
		idle_cycles(1);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		idle_cycles(2);
	endtask

	task automatic send_word(input loader_pkg::ioctl_addr_t addr, input loader_pkg::word_t data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		idle_cycles(1);
		ioctl_wr = 1'b0;
	endtask

	// One cart word, released by the falling ioctl_wait
	task automatic cart_word(input loader_pkg::rom_addr_t addr, input loader_pkg::word_t data);
		send_word(loader_pkg::ioctl_addr_t'(addr), data);
		while (ioctl_wait) begin
			idle_cycles(1);
		end
		check_addr("rom_wr_addr", rom_wr_addr, addr + 24'd2);
	endtask

	//////////////////////////////////////////////////
	// ROM model and output monitors
	//////////////////////////////////////////////////

	initial begin
		logic [2:0] delay;
		rom_wr_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!reset && rom_wr_req !== rom_wr_ack) begin
				for (int b = 0; b < 3; b++) begin
					rom_lfsr = galois_step(rom_lfsr);
					delay = {delay[1:0], rom_lfsr[0]};
				end
				if (delay != 3'd0) begin
					repeat (delay) @(posedge clk_sys);
					#1;
				end
				rom_mem[rom_wr_addr] = rom_wr_data;
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (cd_wr) begin
			cd_bytes.push_back(cd_data);
		end
		if (cheat_valid) begin
			valid_count++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		stop_with_failure();
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("rom_wr_req", rom_wr_req, 1'b0);
		check_bit("cd_wr", cd_wr, 1'b0);
		check_bit("cheat_valid", cheat_valid, 1'b0);
		check_flags("populous", populous, 2'b11);
	endtask

	task automatic test_cart(input logic swap, input loader_pkg::ioctl_index_t index);
		loader_pkg::word_t sent [CART_WORDS];
		loader_pkg::word_t expected;
		swap_bytes = swap;
		rom_mem.delete();
		start_download(index);
		for (int i = 0; i < CART_WORDS; i++) begin
			draw_word(sent[i]);
			cart_word(loader_pkg::rom_addr_t'(2 * i), sent[i]);
		end
		end_download();
		if (rom_mem.num() != CART_WORDS) begin
			$display("ROM model holds %0d words after a %0d word load", rom_mem.num(), CART_WORDS);
			stop_with_failure();
		end
		for (int i = 0; i < CART_WORDS; i++) begin
			expected = swap ? {mirror_byte(sent[i][15:8]), mirror_byte(sent[i][7:0])} : sent[i];
			if (!rom_mem.exists(loader_pkg::rom_addr_t'(2 * i))) begin
				$display("No ROM write arrived at address %0h", 2 * i);
				stop_with_failure();
			end
			check_word("rom word", rom_mem[loader_pkg::rom_addr_t'(2 * i)], expected);
		end
		check_bit("sgx", sgx, index[0]);
	endtask

	task automatic test_signature();
		loader_pkg::rom_addr_t a;
		swap_bytes = 1'b0;
		start_download(8'd0);
		for (int i = 0; i < SIG_WORDS; i++) begin
			a = loader_pkg::rom_addr_t'(2 * i);
			cart_word(a, image_word(a));
		end
		end_download();
		// Bank 1 copy ends in ZZ
		check_flags("populous", populous, 2'b01);
	endtask

	task automatic test_cheat();
		loader_pkg::word_t w [8];
		valid_count = 0;
		start_download(8'hFF);
		for (int i = 0; i < 8; i++) begin
			draw_word(w[i]);
			send_word(loader_pkg::ioctl_addr_t'(2 * i), w[i]);
			idle_cycles(1);
		end
		while (valid_count == 0) begin
			idle_cycles(1);
		end
		idle_cycles(3);
		end_download();
		if (valid_count != 1) begin
			$display("cheat_valid pulsed %0d times for one code", valid_count);
			stop_with_failure();
		end
		check_code("cheat_code", cheat_code, {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
	endtask

	task automatic test_cd_sector();
		loader_pkg::word_t w;
		loader_pkg::byte_t expected [$];
		cd_bytes.delete();
		start_download(8'd2);
		// Mode 1, five bytes
		send_word('0, 16'h8005);
		idle_cycles(4);
		for (int i = 0; i < 3; i++) begin
			draw_word(w);
			expected.push_back(w[7:0]);
			expected.push_back(w[15:8]);
			send_word(loader_pkg::ioctl_addr_t'(2 * i + 2), w);
			idle_cycles(4);
		end
		while (cd_bytes.size() < 5) begin
			idle_cycles(1);
		end
		idle_cycles(8);
		end_download();
		if (cd_bytes.size() != 5) begin
			$display("CD unpacker emitted %0d bytes for a length of 5", cd_bytes.size());
			stop_with_failure();
		end
		for (int i = 0; i < 5; i++) begin
			check_byte("cd_data", cd_bytes[i], expected[i]);
		end
		check_bit("cd_mode", cd_mode, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		swap_bytes = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		idle_cycles(1);
		test_reset();
		test_cart(1'b0, 8'd1);
		test_cart(1'b1, 8'd0);
		test_signature();
		test_cheat();
		test_cd_sector();
		if (DUT.u_checker.assert_errors == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("%0d assertion failures in the DUT checker", DUT.u_checker.assert_errors);
			stop_with_failure();
		end
	end

endmodule

/* tests/loader_checker.sv */
// Bound into every tgfx_loader_top; ack is expected to be the external memory's copy of req
`timescale 1ns/1ps

module loader_checker (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_wait,
	input  logic                   rom_wr_req,
	input  logic                   rom_wr_ack,
	input  loader_pkg::rom_addr_t  rom_wr_addr,
	input  loader_pkg::word_t      rom_wr_data,
	input  logic                   cd_wr,
	input  logic                   cheat_valid
);

	// Failed assertion count
	int assert_errors = 0;

	//////////////////////////////////////////////////
	// ROM write handshake
	//////////////////////////////////////////////////

	wait_while_pending: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_wr_req != rom_wr_ack) |-> ioctl_wait)
	else begin
		assert_errors++;
		$error("ioctl_wait low while a ROM write is pending");
	end

	// Address and data frozen from the toggle until ack matches
	stable_while_pending: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_wr_req != rom_wr_ack) && $stable(rom_wr_req)
		|-> $stable(rom_wr_addr) && $stable(rom_wr_data))
	else begin
		assert_errors++;
		$error("ROM address or data changed while a write is pending");
	end

	//////////////////////////////////////////////////
	// Strobes
	//////////////////////////////////////////////////

	cd_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		cd_wr |=> !cd_wr)
	else begin
		assert_errors++;
		$error("cd_wr high for two cycles");
	end

	cheat_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
	else begin
		assert_errors++;
		$error("cheat_valid high for two cycles");
	end

	wait_low_after_reset: assert property (@(posedge clk_sys) reset |=> !ioctl_wait)
	else begin
		assert_errors++;
		$error("ioctl_wait high after reset");
	end

endmodule

bind tgfx_loader_top loader_checker u_checker (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.ioctl_wait  (ioctl_wait),
	.rom_wr_req  (rom_wr_req),
	.rom_wr_ack  (rom_wr_ack),
	.rom_wr_addr (rom_wr_addr),
	.rom_wr_data (rom_wr_data),
	.cd_wr       (cd_wr),
	.cheat_valid (cheat_valid)
);

/* rtl/tgfx_loader_top.sv */
// Download front end top; ROM ack is the external memory's copy of req, no ROM read path here
`timescale 1ns/1ps

module tgfx_loader_top (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Host download bus
	input  logic                      ioctl_download,
	input  loader_pkg::ioctl_index_t  ioctl_index,
	input  logic                      ioctl_wr,
	input  loader_pkg::ioctl_addr_t   ioctl_addr,
	input  loader_pkg::word_t         ioctl_dout,
	output logic                      ioctl_wait,
	input  logic                      swap_bytes,

	// ROM write port
	output loader_pkg::rom_addr_t     rom_wr_addr,
	output loader_pkg::word_t         rom_wr_data,
	output logic                      rom_wr_req,
	input  logic                      rom_wr_ack,

	output loader_pkg::bank_flags_t   populous,
	output logic                      sgx,

	output loader_pkg::cheat_code_t   cheat_code,
	output logic                      cheat_valid,

	output loader_pkg::byte_t         cd_data,
	output logic                      cd_wr,
	output logic                      cd_mode
);

	ioctl_if   host_bus ();
	rom_wr_if  rom_bus ();

	//////////////////////////////////////////////////
	// Bus hookup
	//////////////////////////////////////////////////

	assign host_bus.download = ioctl_download;
	assign host_bus.index    = ioctl_index;
	assign host_bus.wr       = ioctl_wr;
	assign host_bus.addr     = ioctl_addr;
	assign host_bus.dout     = ioctl_dout;

	assign rom_bus.ack  = rom_wr_ack;
	assign rom_wr_addr  = rom_bus.addr;
	assign rom_wr_data  = rom_bus.data;
	assign rom_wr_req   = rom_bus.req;

	//////////////////////////////////////////////////
	// Consumers
	//////////////////////////////////////////////////

	cart_loader u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host       (host_bus),
		.swap_bytes (swap_bytes),
		.rom        (rom_bus),
		.ioctl_wait (ioctl_wait),
		.sgx        (sgx)
	);

	rom_signature_check u_rom_signature_check (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.rom      (rom_bus),
		.populous (populous)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host_bus),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	cd_sector_unpacker u_cd_sector_unpacker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host    (host_bus),
		.cd_data (cd_data),
		.cd_wr   (cd_wr),
		.cd_mode (cd_mode)
	);

endmodule

/* rtl/cd_sector_unpacker.sv */
// CD data unpacker; the host must leave at least four cycles between data writes
`timescale 1ns/1ps

module cd_sector_unpacker (
	input  logic               clk_sys,
	input  logic               reset,
	ioctl_if.loader            host,
	output loader_pkg::byte_t  cd_data,
	output logic               cd_wr,
	output logic               cd_mode
);

	logic                   cd_download;
	logic                   download_q;
	logic                   download_start;
	loader_pkg::word_t      data_word;
	loader_pkg::cd_len_t    byte_len;
	loader_pkg::cd_len_t    byte_cnt;
	loader_pkg::cd_len_t    byte_cnt_next;
	loader_pkg::cd_state_t  state;

	assign cd_download = host.download && (host.index == loader_pkg::IDX_CD_DATA);
	assign download_start = cd_download && !download_q;
	assign byte_cnt_next = byte_cnt + 15'd1;

	//////////////////////////////////////////////////
	// Header and byte split FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			state      <= loader_pkg::CD_HEADER;
			cd_wr      <= 1'b0;
			cd_mode    <= 1'b0;
			byte_len   <= '0;
			byte_cnt   <= '0;
		end else begin
			download_q <= cd_download;
			cd_wr      <= 1'b0;
			if (download_start) begin
				state    <= loader_pkg::CD_HEADER;
				byte_cnt <= '0;
			end else begin
				case (state)
					loader_pkg::CD_HEADER: begin
						if (host.wr && cd_download) begin
							cd_mode  <= host.dout[loader_pkg::CD_MODE_BIT];
							byte_len <= host.dout[14:0];
							byte_cnt <= '0;
							state    <= loader_pkg::CD_IDLE;
						end
					end
					loader_pkg::CD_IDLE: begin
						// Words past the header length are dropped
						if (host.wr && cd_download && byte_cnt < byte_len) begin
							state <= loader_pkg::CD_LOW_BYTE;
						end
					end
					loader_pkg::CD_LOW_BYTE: begin
						cd_wr    <= 1'b1;
						byte_cnt <= byte_cnt_next;
						if (byte_cnt_next >= byte_len) begin
							state <= loader_pkg::CD_IDLE;
						end else begin
							state <= loader_pkg::CD_HIGH_BYTE;
						end
					end
					loader_pkg::CD_HIGH_BYTE: begin
						// Gap cycle after the low byte strobe
						if (!cd_wr) begin
							cd_wr    <= 1'b1;
							byte_cnt <= byte_cnt_next;
							state    <= loader_pkg::CD_IDLE;
						end
					end
					default: state <= loader_pkg::CD_HEADER;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (state == loader_pkg::CD_IDLE && host.wr && cd_download) begin
			data_word <= host.dout;
		end
		if (state == loader_pkg::CD_LOW_BYTE) begin
			cd_data <= data_word[7:0];
		end else if (state == loader_pkg::CD_HIGH_BYTE && !cd_wr) begin
			cd_data <= data_word[15:8];
		end
	end

endmodule

/* rtl/cheat_code_assembler.sv */
// Cheat code gather; words may arrive in any order, the word at offset 14 closes the code
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                     clk_sys,
	input  logic                     reset,
	ioctl_if.loader                  host,
	output loader_pkg::cheat_code_t  cheat_code,
	output logic                     cheat_valid
);

	logic code_write;

	assign code_write = host.download && host.wr
		&& (host.index[5:0] == loader_pkg::IDX_CHEAT);

	// Low word of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			case (host.addr[3:0])
				4'd0:  cheat_code[111:96]  <= host.dout;
				4'd2:  cheat_code[127:112] <= host.dout;
				4'd4:  cheat_code[79:64]   <= host.dout;
				4'd6:  cheat_code[95:80]   <= host.dout;
				4'd8:  cheat_code[47:32]   <= host.dout;
				4'd10: cheat_code[63:48]   <= host.dout;
				4'd12: cheat_code[15:0]    <= host.dout;
				4'd14: cheat_code[31:16]   <= host.dout;
				default: ;
			endcase
		end
	end

	// One cycle strobe once the replace top word is in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_write && (host.addr[3:0] == 4'd14);
		end
	end

endmodule

/* rtl/rom_signature_check.sv */
// Populous detect; flags only drop inside the two signature blocks and return to 11 on an address 0 write
`timescale 1ns/1ps

module rom_signature_check (
	input  logic                     clk_sys,
	input  logic                     reset,
	rom_wr_if.monitor                rom,
	output loader_pkg::bank_flags_t  populous
);

	logic               req_q;
	logic               req_toggle;
	logic               in_block;
	logic               sig_offset;
	loader_pkg::word_t  sig_expect;

	assign req_toggle = rom.req != req_q;

	assign in_block = (rom.addr[23:4] == loader_pkg::SIG_BLOCK_LO)
		|| (rom.addr[23:4] == loader_pkg::SIG_BLOCK_HI);

	// Expected word at each checked offset
	always_comb begin
		sig_offset = 1'b1;
		sig_expect = loader_pkg::SIG_WORD_0;
		case (rom.addr[3:0])
			4'd6:  sig_expect = loader_pkg::SIG_WORD_0;
			4'd8:  sig_expect = loader_pkg::SIG_WORD_1;
			4'd10: sig_expect = loader_pkg::SIG_WORD_2;
			4'd12: sig_expect = loader_pkg::SIG_WORD_3;
			default: sig_offset = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_q    <= 1'b0;
			populous <= 2'b11;
		end else begin
			req_q <= rom.req;
			if (req_toggle) begin
				if (rom.addr == '0) begin
					populous <= 2'b11;
				end else if (in_block && sig_offset && rom.data != sig_expect) begin
					populous[rom.addr[loader_pkg::SIG_BANK_BIT]] <= 1'b0;
				end
			end
		end
	end

endmodule

/* rtl/cart_loader.sv */
// Cart ROM writer; the host must not pulse wr while ioctl_wait is high, ack held stalls it forever
`timescale 1ns/1ps

module cart_loader (
	input  logic            clk_sys,
	input  logic            reset,
	ioctl_if.loader         host,
	input  logic            swap_bytes,
	rom_wr_if.source        rom,
	output logic            ioctl_wait,
	output logic            sgx
);

	logic                    cart_download;
	logic                    download_q;
	logic                    download_start;
	loader_pkg::word_t       swapped_word;
	loader_pkg::word_t       wr_word;
	loader_pkg::rom_addr_t   wr_addr;
	loader_pkg::rom_state_t  state;

	//////////////////////////////////////////////////
	// Download decode
	//////////////////////////////////////////////////

	assign cart_download = host.download && (host.index[5:0] <= loader_pkg::IDX_CART_MAX);
	assign download_start = cart_download && !download_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
		end else begin
			download_q <= cart_download;
		end
	end

	// Bit order reversed inside each byte, byte positions kept
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped_word[i]     = host.dout[7 - i];
			swapped_word[8 + i] = host.dout[15 - i];
		end
	end

	//////////////////////////////////////////////////
	// Write FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= loader_pkg::ROM_IDLE;
			rom.req    <= 1'b0;
			ioctl_wait <= 1'b0;
			wr_addr    <= '0;
			sgx        <= 1'b0;
		end else if (download_start) begin
			wr_addr <= '0;
			sgx     <= host.index[0];
		end else begin
			case (state)
				loader_pkg::ROM_IDLE: begin
					if (host.wr && cart_download) begin
						rom.req    <= ~rom.req;
						ioctl_wait <= 1'b1;
						state      <= loader_pkg::ROM_WAIT_ACK;
					end
				end
				loader_pkg::ROM_WAIT_ACK: begin
					// Memory has taken the word, release the host
					if (rom.ack == rom.req) begin
						ioctl_wait <= 1'b0;
						wr_addr    <= wr_addr + 24'd2;
						state      <= loader_pkg::ROM_IDLE;
					end
				end
				default: state <= loader_pkg::ROM_IDLE;
			endcase
		end
	end

	// Data word held until the next accepted write
	always_ff @(posedge clk_sys) begin
		if (state == loader_pkg::ROM_IDLE && host.wr && cart_download && !download_start) begin
			wr_word <= swap_bytes ? swapped_word : host.dout;
		end
	end

	assign rom.addr = wr_addr;
	assign rom.data = wr_word;

endmodule

/* rtl/rom_wr_if.sv */
// ROM write with toggle handshake; a write is pending while req differs from ack
`timescale 1ns/1ps

interface rom_wr_if;

	loader_pkg::rom_addr_t  addr;
	loader_pkg::word_t      data;
	logic                   req;
	logic                   ack;

	// Writer toggles req with addr and data already stable
	modport source (
		output addr, data, req,
		input  ack
	);

	// External memory answers by copying req into ack
	modport sink (
		input  addr, data, req,
		output ack
	);

	modport monitor (
		input addr, data, req, ack
	);

endinterface

/* rtl/ioctl_if.sv */
// Host download bus; wr is a one-cycle pulse and is only meaningful while download is high
`timescale 1ns/1ps

interface ioctl_if;

	logic                      download;
	loader_pkg::ioctl_index_t  index;
	logic                      wr;
	loader_pkg::ioctl_addr_t   addr;
	loader_pkg::word_t         dout;

	// Host side, filled from the top level ports
	modport driver (
		output download, index, wr, addr, dout
	);

	// Cart, cheat and CD consumers only listen
	modport loader (
		input download, index, wr, addr, dout
	);

endinterface

/* rtl/loader_pkg.sv */
// Shared widths, download indices and Populous signature constants; byte addresses throughout
package loader_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	typedef logic [15:0]  word_t;
	typedef logic [24:0]  ioctl_addr_t;
	typedef logic [7:0]   ioctl_index_t;
	typedef logic [23:0]  rom_addr_t;
	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [127:0] cheat_code_t;
	typedef logic [14:0]  cd_len_t;
	typedef logic [7:0]   byte_t;
	// One flag per signature bank
	typedef logic [1:0]   bank_flags_t;

	typedef enum logic [1:0] {
		CD_HEADER,
		CD_IDLE,
		CD_LOW_BYTE,
		CD_HIGH_BYTE
	} cd_state_t;

	typedef enum logic {
		ROM_IDLE,
		ROM_WAIT_ACK
	} rom_state_t;

	//////////////////////////////////////////////////
	// Download indices
	//////////////////////////////////////////////////

	// Cart and cheat decode use the low six index bits only
	localparam logic [5:0] IDX_CART_MAX = 6'd1;
	localparam ioctl_index_t IDX_CD_DATA = 8'd2;
	localparam logic [5:0] IDX_CHEAT = 6'h3F;

	//////////////////////////////////////////////////
	// Populous signature
	//////////////////////////////////////////////////

	// ROM word blocks, compared against address bits 23:4
	localparam logic [19:0] SIG_BLOCK_LO = 20'h1F2;
	localparam logic [19:0] SIG_BLOCK_HI = 20'h212;
	localparam int SIG_BANK_BIT = 13;
	// "PO", "PU", "LO", "US" with the first character in the low byte
	localparam word_t SIG_WORD_0 = 16'h4F50;
	localparam word_t SIG_WORD_1 = 16'h5550;
	localparam word_t SIG_WORD_2 = 16'h4F4C;
	localparam word_t SIG_WORD_3 = 16'h5355;

	// CD header is {mode, length}
	localparam int CD_MODE_BIT = 15;

endpackage
